//--- filelist.f
+incdir+.
isa_pkg.sv
fetch_pkg.sv
fetch_ctrl.sv
fetch_buffer.sv
predecode_lane.sv
issue_pack.sv
fetch_top.sv
tb_clock.sv
fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f filelist.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

//--- fetch_tb.sv
module fetch_tb
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_events = 10;
  localparam int tail_bundles = 4;
  localparam instr_t nop_instr = 32'h0000_0013;

  // trigger pc, {trap, mret, miss, fence}, target base, stall cycles
  localparam logic [75:0] event_table [num_events] = '{
    {32'h0000_0008, 4'b0000, 32'h0000_0000, 8'd3},
    {32'h0000_00a0, 4'b1000, 32'h0000_0200, 8'd0},
    {32'h0000_0208, 4'b0100, 32'h0000_0300, 8'd0},
    {32'h0000_0348, 4'b0010, 32'h0000_0400, 8'd0},
    {32'h0000_0488, 4'b0001, 32'h0000_0500, 8'd0},
    {32'h0000_05c8, 4'b1010, 32'h0000_0600, 8'd0},
    {32'h0000_0608, 4'b0101, 32'h0000_0700, 8'd0},
    {32'h0000_0748, 4'b0011, 32'h0000_0800, 8'd0},
    {32'h0000_0888, 4'b0000, 32'h0000_0000, 8'd5},
    {32'h0000_0890, 4'b0001, 32'h0000_1000, 8'd0}
  };

  logic clock, reset, enable, stall;
  logic trap, mret, miss, fence;
  addr_t mtvec, mepc, miss_addr, fence_npc;
  logic mem_valid, mem_fence, mem_spec, mem_ready;
  addr_t mem_addr;
  fetch_word_t mem_rdata;
  logic out_valid, out_valid1;
  addr_t out_pc0, out_pc1;
  instr_t out_instr0, out_instr1;

  addr_t exp_pc [$];
  logic exp_kill [$]; // slot 1 dropped behind a jal in slot 0
  int errors = 0;
  int checks = 0;
  int fence_seen = 0;
  int fence_expected = 0;
  int stall_total = 0;
  logic [31:0] lfsr = 32'hc11d_2d9f;
  logic answered_in_stall = 1'b0;

  tb_clock tb_clock_inst (
    .clock(clock),
    .reset(reset)
  );

  fetch_top fetch_top_inst (
    .clock(clock), .reset(reset), .enable(enable), .stall(stall),
    .trap(trap), .mtvec(mtvec), .mret(mret), .mepc(mepc),
    .miss(miss), .miss_addr(miss_addr), .fence(fence), .fence_npc(fence_npc),
    .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_fence(mem_fence),
    .mem_spec(mem_spec), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
    .out_valid(out_valid), .out_pc0(out_pc0), .out_instr0(out_instr0),
    .out_pc1(out_pc1), .out_instr1(out_instr1), .out_valid1(out_valid1)
  );

  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // jal at two fixed addresses and filler everywhere else
  function automatic logic jal_at(addr_t a);
    return (a == 32'h18) || (a == 32'h64);
  endfunction

  function automatic addr_t jal_offset_at(addr_t a);
    return (a == 32'h18) ? 32'h40 : 32'h3c;
  endfunction

  function automatic instr_t jal_instr(addr_t off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111}; // jal x1
  endfunction

  function automatic instr_t instr_at(addr_t a);
    if (jal_at(a)) begin
      return jal_instr(jal_offset_at(a));
    end
    // addi with fields folded from all address bits
    return {a[13:2] ^ a[25:14], a[30:26], 3'b000, a[31:27] ^ a[4:0], 7'b0010011};
  endfunction

  // trap, mret, miss, fence targets sit 0x40 apart from the entry base
  function automatic addr_t event_target(logic [3:0] mask, addr_t base);
    if (mask[3]) return base;
    if (mask[2]) return base + 32'h40;
    if (mask[1]) return base + 32'h80;
    return base + 32'hc0;
  endfunction

  task automatic build_model();
    addr_t pc;
    addr_t next;
    logic [3:0] mask;
    int ev;
    int tail;
    pc = '0;
    ev = 0;
    tail = 0;
    while (tail < tail_bundles && exp_pc.size() < 200) begin
      exp_pc.push_back(pc);
      exp_kill.push_back(jal_at(pc));
      if (jal_at(pc)) next = pc + jal_offset_at(pc);
      else if (jal_at(pc + 4)) next = pc + 4 + jal_offset_at(pc + 4);
      else next = pc + 8;
      if (ev < num_events && pc == event_table[ev][75:44]) begin
        mask = event_table[ev][43:40];
        stall_total += int'(event_table[ev][7:0]);
        if (mask != 4'b0000) next = event_target(mask, event_table[ev][39:8]);
        if (mask[0] && mask[3:1] == 3'b000) fence_expected++;
        ev++;
      end
      if (ev == num_events) tail++;
      pc = next;
    end
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // issue outputs against model entry idx
  task automatic check_bundle(string name, int idx);
    addr_t pc;
    logic kill;
    pc = exp_pc[idx];
    kill = exp_kill[idx];
    check_value({name, " pc0"}, pc, out_pc0);
    check_value({name, " instr0"}, instr_at(pc), out_instr0);
    check_value({name, " pc1"}, pc + 4, out_pc1);
    check_value({name, " valid1"}, 32'(!kill), 32'(out_valid1));
    check_value({name, " instr1"}, kill ? nop_instr : instr_at(pc + 4), out_instr1);
  endtask

  // memory responder and cycle checks sampled at the falling edge
  initial begin
    logic pending;
    addr_t pend_addr;
    int wait_cycles;
    pending = 1'b0;
    pend_addr = '0;
    wait_cycles = 0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge clock);
      if (reset && mem_valid) begin
        if (pending) begin
          errors++;
          $display("error: new memory request while an answer is still pending");
        end
        pending = 1'b1;
        pend_addr = mem_addr;
        wait_cycles = 1;
        if (lfsr_bit()) wait_cycles += 2;
        if (lfsr_bit()) wait_cycles += 1;
      end
      if (mem_fence) fence_seen++;
      if (reset && !enable) begin
        check_value("idle mem_valid", 32'd0, 32'(mem_valid));
        check_value("idle mem_fence", 32'd0, 32'(mem_fence));
        check_value("idle mem_spec", 32'd0, 32'(mem_spec));
        check_value("idle out_valid", 32'd0, 32'(out_valid));
      end
      // buffer is full once an answer lands during stall
      if (stall && (mem_ready || answered_in_stall)) begin
        check_value("mem_valid while full", 32'd0, 32'(mem_valid));
      end
      answered_in_stall = stall && (mem_ready || answered_in_stall);
      @(posedge clock);
      #1;
      mem_ready = 1'b0;
      if (pending) begin
        wait_cycles--;
        if (wait_cycles == 0) begin
          mem_ready = 1'b1;
          mem_rdata = {instr_at(pend_addr + 4), instr_at(pend_addr)};
          pending = 1'b0;
        end
      end
    end
  end

  initial begin
    int got;
    int ev;
    int cycles;
    int limit;
    int stall_left;
    addr_t pc;
    logic [3:0] mask;
    addr_t base;
    got = 0;
    ev = 0;
    cycles = 0;
    stall_left = 0;
    enable = 1'b0;
    stall = 1'b0;
    trap = 1'b0;
    mret = 1'b0;
    miss = 1'b0;
    fence = 1'b0;
    mtvec = '0;
    mepc = '0;
    miss_addr = '0;
    fence_npc = '0;
    build_model();
    limit = 100 + exp_pc.size() * 12 + stall_total; // up to two 4-cycle latencies per bundle
    wait (reset === 1'b1);
    repeat (5) @(posedge clock); // enable still low here
    #1 enable = 1'b1;
    while (got < exp_pc.size() && cycles < limit) begin
      @(posedge clock);
      #1;
      cycles++;
      trap = 1'b0;
      mret = 1'b0;
      miss = 1'b0;
      fence = 1'b0;
      if (stall) begin
        check_value("stall out_valid", 32'd1, 32'(out_valid));
        check_bundle("stall", got - 1);
      end else if (out_valid) begin
        pc = exp_pc[got];
        check_bundle($sformatf("bundle %0d", got), got);
        if (ev < num_events && pc == event_table[ev][75:44]) begin
          mask = event_table[ev][43:40];
          base = event_table[ev][39:8];
          mtvec = base;
          mepc = base + 32'h40;
          miss_addr = base + 32'h80;
          fence_npc = base + 32'hc0;
          trap = mask[3];
          mret = mask[2];
          miss = mask[1];
          fence = mask[0];
          stall_left = int'(event_table[ev][7:0]);
          ev++;
        end
        got++;
      end
      stall = (stall_left != 0);
      if (stall_left != 0) stall_left--;
    end
    repeat (2) @(posedge clock);
    if (got < exp_pc.size()) begin
      errors++;
      $display("timeout: only %0d of %0d bundles arrived in %0d cycles",
               got, exp_pc.size(), limit);
    end
    check_value("fence pulses", 32'(fence_expected), 32'(fence_seen));
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb_clock.sv
module tb_clock (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock; // 10 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (10) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

//--- fetch_top.sv
`include "fetch_macros.svh"

module fetch_top
  import fetch_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic enable,
  input logic stall,
  input logic trap,
  input addr_t mtvec,
  input logic mret,
  input addr_t mepc,
  input logic miss,
  input addr_t miss_addr,
  input logic fence,
  input addr_t fence_npc,
  output logic mem_valid,
  output addr_t mem_addr,
  output logic mem_fence,
  output logic mem_spec,
  input logic mem_ready,
  input fetch_word_t mem_rdata,
  output logic out_valid,
  output addr_t out_pc0,
  output instr_t out_instr0,
  output addr_t out_pc1,
  output instr_t out_instr1,
  output logic out_valid1
);

  logic resp_valid;
  addr_t req_pc;
  logic clear;
  logic full;
  logic pred_taken;
  addr_t pred_taddr;

  // per lane, index 0 is the slot at the fetch pc
  addr_t slot_pc [`FETCH_LANES];
  instr_t slot_instr [`FETCH_LANES];
  logic slot_valid [`FETCH_LANES];
  logic taken [`FETCH_LANES];
  addr_t taddr [`FETCH_LANES];

  fetch_ctrl fetch_ctrl_inst (
    .clock(clock),
    .reset(reset),
    .enable(enable),
    .trap(trap),
    .mtvec(mtvec),
    .mret(mret),
    .mepc(mepc),
    .miss(miss),
    .miss_addr(miss_addr),
    .fence(fence),
    .fence_npc(fence_npc),
    .pred_taken(pred_taken),
    .pred_taddr(pred_taddr),
    .full(full),
    .mem_ready(mem_ready),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_fence(mem_fence),
    .mem_spec(mem_spec),
    .resp_valid(resp_valid),
    .req_pc(req_pc),
    .clear(clear)
  );

  fetch_buffer fetch_buffer_inst (
    .clock(clock),
    .reset(reset),
    .resp_valid(resp_valid),
    .req_pc(req_pc),
    .mem_rdata(mem_rdata),
    .clear(clear),
    .stall(stall),
    .slot_pc0(slot_pc[0]),
    .slot_instr0(slot_instr[0]),
    .slot_valid0(slot_valid[0]),
    .slot_pc1(slot_pc[1]),
    .slot_instr1(slot_instr[1]),
    .slot_valid1(slot_valid[1]),
    .full(full)
  );

  for (genvar lane = 0; lane < `FETCH_LANES; lane++) begin : gen_lane
    predecode_lane predecode_lane_inst (
      .pc(slot_pc[lane]),
      .instr(slot_instr[lane]),
      .valid(slot_valid[lane]),
      .taken(taken[lane]),
      .taddr(taddr[lane])
    );
  end

  issue_pack issue_pack_inst (
    .clock(clock),
    .reset(reset),
    .stall(stall),
    .slot_pc0(slot_pc[0]),
    .slot_instr0(slot_instr[0]),
    .slot_valid0(slot_valid[0]),
    .slot_pc1(slot_pc[1]),
    .slot_instr1(slot_instr[1]),
    .slot_valid1(slot_valid[1]),
    .taken0(taken[0]),
    .taddr0(taddr[0]),
    .taken1(taken[1]),
    .taddr1(taddr[1]),
    .out_valid(out_valid),
    .out_pc0(out_pc0),
    .out_instr0(out_instr0),
    .out_pc1(out_pc1),
    .out_instr1(out_instr1),
    .out_valid1(out_valid1),
    .pred_taken(pred_taken),
    .pred_taddr(pred_taddr)
  );

endmodule

//--- issue_pack.sv
module issue_pack
  import fetch_pkg::*;
  import isa_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic stall,
  input addr_t slot_pc0,
  input instr_t slot_instr0,
  input logic slot_valid0,
  input addr_t slot_pc1,
  input instr_t slot_instr1,
  input logic slot_valid1,
  input logic taken0,
  input addr_t taddr0,
  input logic taken1,
  input addr_t taddr1,
  output logic out_valid,
  output addr_t out_pc0,
  output instr_t out_instr0,
  output addr_t out_pc1,
  output instr_t out_instr1,
  output logic out_valid1,
  output logic pred_taken,
  output addr_t pred_taddr
);

  localparam instr_t nop = instr_t'({25'b0, op_imm}); // addi x0, x0, 0

  logic keep1;

  always_comb begin
    keep1 = slot_valid1 && !taken0; // slot 1 is dead behind a taken jal
    pred_taken = taken0 || (taken1 && keep1);
    pred_taddr = taken0 ? taddr0 : taddr1;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      out_valid <= 1'b0;
      out_valid1 <= 1'b0;
    end else if (!stall) begin
      out_valid <= slot_valid0;
      out_valid1 <= slot_valid0 && keep1;
    end
  end

  // bundle stays put while the issue stage stalls
  always_ff @(posedge clock) begin
    if (!stall && slot_valid0) begin
      out_pc0 <= slot_pc0;
      out_instr0 <= slot_instr0;
      out_pc1 <= slot_pc1;
      out_instr1 <= keep1 ? slot_instr1 : nop;
    end
  end

endmodule

//--- predecode_lane.sv
module predecode_lane
  import fetch_pkg::*;
  import isa_pkg::*;
(
  input addr_t pc,
  input instr_t instr,
  input logic valid,
  output logic taken,
  output addr_t taddr
);

  opcode_t opcode;
  jimm_t jimm;

  always_comb begin
    opcode = opcode_t'(instr[6:0]);

    // imm[20|10:1|11|19:12] scattered over the upper bits
    jimm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // static prediction, jal is always taken
    taken = valid && (opcode == op_jal);
    taddr = pc + jimm;
  end

endmodule

//--- fetch_buffer.sv
`include "fetch_macros.svh"

module fetch_buffer
  import fetch_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic resp_valid,
  input addr_t req_pc,
  input fetch_word_t mem_rdata,
  input logic clear,
  input logic stall,
  output addr_t slot_pc0,
  output instr_t slot_instr0,
  output logic slot_valid0,
  output addr_t slot_pc1,
  output instr_t slot_instr1,
  output logic slot_valid1,
  output logic full
);

  logic held;
  addr_t held_pc;
  fetch_word_t held_word;
  logic cur_valid;
  addr_t cur_pc;
  fetch_word_t cur_word;

  // a fresh answer passes straight through, a held one comes from the register
  always_comb begin
    cur_valid = (resp_valid || held) && !clear;
    cur_pc = resp_valid ? req_pc : held_pc;
    cur_word = resp_valid ? mem_rdata : held_word;

    full = cur_valid && stall; // occupied in the next cycle

    slot_valid0 = cur_valid;
    slot_valid1 = cur_valid;
    slot_pc0 = cur_pc;
    slot_pc1 = cur_pc + addr_t'(`INSTR_WIDTH / 8);
    slot_instr0 = cur_word[`INSTR_WIDTH-1:0];
    slot_instr1 = cur_word[`FETCH_WIDTH-1:`INSTR_WIDTH];
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      held <= 1'b0;
    end else begin
      held <= full;
    end
  end

  always_ff @(posedge clock) begin
    if (resp_valid && stall) begin
      held_pc <= req_pc;
      held_word <= mem_rdata;
    end
  end

endmodule

//--- fetch_ctrl.sv
`include "fetch_macros.svh"

module fetch_ctrl
  import fetch_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic enable,
  input logic trap,
  input addr_t mtvec,
  input logic mret,
  input addr_t mepc,
  input logic miss,
  input addr_t miss_addr,
  input logic fence,
  input addr_t fence_npc,
  input logic pred_taken,
  input addr_t pred_taddr,
  input logic full,
  input logic mem_ready,
  output logic mem_valid,
  output addr_t mem_addr,
  output logic mem_fence,
  output logic mem_spec,
  output logic resp_valid,
  output addr_t req_pc,
  output logic clear
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  addr_t pc_q; // pending request address, or the next one to issue
  addr_t pc_d;
  addr_t target;
  addr_t seq_pc;
  logic redirect;
  logic fence_win;
  logic launch;

  // redirect priority, trap highest
  always_comb begin
    redirect = trap || mret || miss || fence;
    fence_win = fence && !(trap || mret || miss);
    if (trap) begin
      target = mtvec;
    end else if (mret) begin
      target = mepc;
    end else if (miss) begin
      target = miss_addr;
    end else begin
      target = fence_npc;
    end
    // only looked at while an answer is accepted
    seq_pc = pred_taken ? pred_taddr : pc_q + addr_t'(`FETCH_BYTES);
  end

  always_comb begin
    state_d = state_q;
    pc_d = pc_q;
    launch = 1'b0;
    resp_valid = 1'b0;
    mem_valid = 1'b0;

    case (state_q)
      idle: begin
        launch = enable; // nothing leaves before enable
      end
      busy: begin
        if (mem_ready) begin
          launch = 1'b1;
          resp_valid = !redirect; // a redirect drops this answer
          pc_d = seq_pc;
        end else if (redirect) begin
          state_d = fence_win ? inv : ctrl;
        end
      end
      ctrl, inv: begin
        if (mem_ready) begin
          launch = 1'b1; // swallow the stale answer
        end else if (fence_win) begin
          state_d = inv;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase

    if (redirect) begin
      pc_d = target;
    end

    // hold off while the buffer cannot take another answer
    if (launch) begin
      mem_valid = !full;
      state_d = full ? idle : busy;
    end

    mem_addr = pc_d;
    mem_fence = fence_win;
    mem_spec = redirect;
    clear = redirect;
    req_pc = pc_q;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      pc_q <= '0;
    end else begin
      state_q <= state_d;
      pc_q <= pc_d;
    end
  end

endmodule

//--- fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

  typedef logic [31:0] addr_t; // byte address

  typedef logic [`INSTR_WIDTH-1:0] instr_t;

  // low half is the instruction at pc, high half the one at pc + 4
  typedef logic [`FETCH_WIDTH-1:0] fetch_word_t;

  typedef enum logic [1:0] {
    idle, // no request outstanding
    busy, // waiting for a wanted answer
    ctrl, // redirected, the pending answer gets dropped
    inv   // same as ctrl, after a fence
  } fetch_state_t;

endpackage

//--- isa_pkg.sv
`include "fetch_macros.svh"

package isa_pkg;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    op_load = 7'b0000011,
    op_misc_mem = 7'b0001111, // fence, fence.i
    op_imm = 7'b0010011,
    op_auipc = 7'b0010111,
    op_store = 7'b0100011,
    op_reg = 7'b0110011,
    op_lui = 7'b0110111,
    op_branch = 7'b1100011,
    op_jalr = 7'b1100111,
    op_jal = `JAL_OPCODE,
    op_system = 7'b1110011
  } opcode_t;

  typedef logic [31:0] jimm_t; // sign-extended j-type immediate

endpackage

//--- fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// one instruction slot
`define INSTR_WIDTH 32

// slots per fetch word
`define FETCH_LANES 2

// bits in one memory answer
`define FETCH_WIDTH (`INSTR_WIDTH * `FETCH_LANES)

// pc step for one fetch
`define FETCH_BYTES 8

`define JAL_OPCODE 7'b1101111

`endif
